// ==== src/nf_pkg.sv ====
//**************************************************
// shared definitions for the peripheral subsystem
//   bus widths and router slot count
//   slave select field and address map
//   AXI response encoding
//   GPIO and PWM register offsets
//**************************************************

`default_nettype none

package nf_pkg;

    localparam int DATA_W  = 32;                        // bus data width
    localparam int ADDR_W  = 16;                        // AXI byte address width
    localparam int SLAVE_N = 4;                         // router slots
    localparam int SEL_LSB = 12;                        // select field is [13:12]

    localparam logic [1 : 0] SEL_RAM  = 2'd0;           // data RAM
    localparam logic [1 : 0] SEL_GPIO = 2'd1;           // GPIO block
    localparam logic [1 : 0] SEL_PWM  = 2'd2;           // PWM block, code 3 unmapped

    typedef enum logic [1 : 0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    localparam logic [SEL_LSB-1 : 0] GPIO_GPI_OFS  = 'h0;  // synchronized input
    localparam logic [SEL_LSB-1 : 0] GPIO_GPO_OFS  = 'h4;  // output value
    localparam logic [SEL_LSB-1 : 0] GPIO_GPD_OFS  = 'h8;  // direction
    localparam logic [SEL_LSB-1 : 0] PWM_DUTY_OFS  = 'h0;  // duty compare value
    localparam logic [SEL_LSB-1 : 0] PWM_PRESC_OFS = 'h4;  // prescale divider

endpackage : nf_pkg

`default_nettype wire

// ==== src/nf_axil_slave.sv ====
//**************************************************
// AXI4-Lite slave front end
//   one transaction at a time, write has priority
//   issues single-cycle internal bus strobes
//   holds B and R responses until accepted
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_axil_slave
(
    input   logic   [0 : 0]                 clk,        // clock
    input   logic   [0 : 0]                 rst,        // sync reset
    // write address / data / response
    input   logic   [0 : 0]                 awvalid,
    output  logic   [0 : 0]                 awready,
    input   logic   [nf_pkg::ADDR_W-1 : 0]  awaddr,
    input   logic   [0 : 0]                 wvalid,
    output  logic   [0 : 0]                 wready,
    input   logic   [nf_pkg::DATA_W-1 : 0]  wdata,
    input   logic   [3 : 0]                 wstrb,      // ignored, full-word writes
    output  logic   [0 : 0]                 bvalid,
    input   logic   [0 : 0]                 bready,
    output  nf_pkg::resp_t                  bresp,
    // read address / data
    input   logic   [0 : 0]                 arvalid,
    output  logic   [0 : 0]                 arready,
    input   logic   [nf_pkg::ADDR_W-1 : 0]  araddr,
    output  logic   [0 : 0]                 rvalid,
    input   logic   [0 : 0]                 rready,
    output  logic   [nf_pkg::DATA_W-1 : 0]  rdata,
    output  nf_pkg::resp_t                  rresp,
    // internal bus
    output  logic   [nf_pkg::ADDR_W-1 : 0]  bus_addr,   // word aligned
    output  logic   [0 : 0]                 bus_we,
    output  logic   [0 : 0]                 bus_re,
    output  logic   [nf_pkg::DATA_W-1 : 0]  bus_wd,
    input   logic   [nf_pkg::DATA_W-1 : 0]  bus_rd,
    input   logic   [0 : 0]                 bus_err
);

    typedef enum logic [1 : 0] { IDLE, WRESP, RWAIT, RRESP } state_t;

    state_t             state;
    logic   [0 : 0]     wr_go;                          // aw+w handshake this cycle
    logic   [0 : 0]     rd_go;                          // ar handshake this cycle

    assign wr_go   = (state == IDLE) && awvalid && wvalid;
    assign rd_go   = (state == IDLE) && arvalid && !(awvalid && wvalid);  // write wins

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;
    assign bvalid  = (state == WRESP);
    assign rvalid  = (state == RRESP);

    assign bus_we   = wr_go;
    assign bus_re   = rd_go;
    assign bus_wd   = wdata;
    assign bus_addr = wr_go ? {awaddr[nf_pkg::ADDR_W-1 : 2], 2'b00}
                            : {araddr[nf_pkg::ADDR_W-1 : 2], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE    : if (wr_go) state <= WRESP;
                          else if (rd_go) state <= RWAIT;
                WRESP   : if (bready) state <= IDLE;
                RWAIT   : state <= RRESP;       // slave data lands here
                RRESP   : if (rready) state <= IDLE;
                default : state <= IDLE;
            endcase
        end
    end

    // response payload, held stable while waiting on the master
    always_ff @(posedge clk) begin
        if (wr_go)
            bresp <= bus_err ? nf_pkg::RESP_SLVERR : nf_pkg::RESP_OKAY;
        if (state == RWAIT) begin
            rdata <= bus_rd;
            rresp <= bus_err ? nf_pkg::RESP_SLVERR : nf_pkg::RESP_OKAY;
        end
    end

endmodule : nf_axil_slave

`default_nettype wire

// ==== src/nf_router.sv ====
//**************************************************
// address router
//   select field decode into per-slave strobes
//   registered slot for the read-data mux
//   decode error for the unmapped slot
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_router
(
    input   logic   [0 : 0]                                     clk,
    input   logic   [0 : 0]                                     rst,
    // front end side
    input   logic   [nf_pkg::ADDR_W-1 : 0]                      bus_addr,
    input   logic   [0 : 0]                                     bus_we,
    input   logic   [0 : 0]                                     bus_re,
    input   logic   [nf_pkg::DATA_W-1 : 0]                      bus_wd,
    output  logic   [nf_pkg::DATA_W-1 : 0]                      bus_rd,
    output  logic   [0 : 0]                                     bus_err,
    // slave side
    output  logic   [nf_pkg::SEL_LSB-1 : 0]                     addr_s,  // offset in slot
    output  logic   [nf_pkg::DATA_W-1 : 0]                      wd_s,
    output  logic   [nf_pkg::SLAVE_N-1 : 0]                     we_s,
    output  logic   [nf_pkg::SLAVE_N-1 : 0]                     re_s,
    input   logic   [nf_pkg::SLAVE_N-1 : 0][nf_pkg::DATA_W-1 : 0] rd_s
);

    logic   [1 : 0]     sel;                            // current select field
    logic   [1 : 0]     sel_q;                          // slot of last read

    function automatic logic unmapped(input logic [1 : 0] s);
        return !(s == nf_pkg::SEL_RAM || s == nf_pkg::SEL_GPIO || s == nf_pkg::SEL_PWM);
    endfunction

    assign sel    = bus_addr[nf_pkg::SEL_LSB +: 2];
    assign addr_s = bus_addr[nf_pkg::SEL_LSB-1 : 0];
    assign wd_s   = bus_wd;
    assign we_s   = bus_we ? nf_pkg::SLAVE_N'(1) << sel : '0;
    assign re_s   = bus_re ? nf_pkg::SLAVE_N'(1) << sel : '0;

    always_ff @(posedge clk) begin
        if (rst)
            sel_q <= nf_pkg::SEL_RAM;
        else if (bus_re)
            sel_q <= sel;                               // lines up with slave rd regs
    end

    // writes decode now, reads use the slot captured a cycle ago
    assign bus_err = bus_we ? unmapped(sel) : unmapped(sel_q);
    assign bus_rd  = unmapped(sel_q) ? '0 : rd_s[sel_q];

endmodule : nf_router

`default_nettype wire

// ==== src/nf_ram.sv ====
//**************************************************
// data RAM
//   word addressed, aliases modulo depth
//   registered read on re
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_ram
#(
    parameter int depth = 64                            // words, power of two
)(
    input   logic   [0 : 0]                     clk,
    input   logic   [0 : 0]                     we,
    input   logic   [0 : 0]                     re,
    input   logic   [nf_pkg::SEL_LSB-1 : 0]     addr,   // byte offset
    input   logic   [nf_pkg::DATA_W-1 : 0]      wd,
    output  logic   [nf_pkg::DATA_W-1 : 0]      rd
);

    localparam int aw = $clog2(depth);

    logic   [nf_pkg::DATA_W-1 : 0]  mem [depth];
    logic   [aw-1 : 0]              word;

    assign word = addr[2 +: aw];                        // drop byte bits, wrap at depth

    always_ff @(posedge clk) begin
        if (we)
            mem[word] <= wd;
        if (re)
            rd <= mem[word];
    end

endmodule : nf_ram

`default_nettype wire

// ==== src/nf_gpio.sv ====
//**************************************************
// GPIO block
//   output and direction registers
//   two-flop synchronizer on the input pins
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_gpio
#(
    parameter int gpio_w = 8
)(
    input   logic   [0 : 0]                     clk,
    input   logic   [0 : 0]                     rst,
    // router side
    input   logic   [0 : 0]                     we,
    input   logic   [0 : 0]                     re,
    input   logic   [nf_pkg::SEL_LSB-1 : 0]     addr,
    input   logic   [nf_pkg::DATA_W-1 : 0]      wd,
    output  logic   [nf_pkg::DATA_W-1 : 0]      rd,
    // pins
    input   logic   [gpio_w-1 : 0]              gpi,
    output  logic   [gpio_w-1 : 0]              gpo,
    output  logic   [gpio_w-1 : 0]              gpd
);

    logic   [gpio_w-1 : 0]  gpi_m;                      // first sync stage
    logic   [gpio_w-1 : 0]  gpi_s;                      // safe to read

    always_ff @(posedge clk) begin
        gpi_m <= gpi;
        gpi_s <= gpi_m;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpo <= '0;
            gpd <= '0;                                  // all pins start as inputs
        end else if (we) begin
            if (addr == nf_pkg::GPIO_GPO_OFS) gpo <= wd[gpio_w-1 : 0];
            if (addr == nf_pkg::GPIO_GPD_OFS) gpd <= wd[gpio_w-1 : 0];
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            case (addr)
                nf_pkg::GPIO_GPI_OFS : rd <= nf_pkg::DATA_W'(gpi_s);
                nf_pkg::GPIO_GPO_OFS : rd <= nf_pkg::DATA_W'(gpo);
                nf_pkg::GPIO_GPD_OFS : rd <= nf_pkg::DATA_W'(gpd);
                default              : rd <= '0;    // hole in the map
            endcase
        end
    end

endmodule : nf_gpio

`default_nettype wire

// ==== src/nf_pwm.sv ====
//**************************************************
// PWM generator
//   prescaler strobe every presc+1 clocks
//   period counter compared against duty
//   registered output
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_pwm
#(
    parameter int pwm_w = 8
)(
    input   logic   [0 : 0]                     clk,
    input   logic   [0 : 0]                     rst,
    // router side
    input   logic   [0 : 0]                     we,
    input   logic   [0 : 0]                     re,
    input   logic   [nf_pkg::SEL_LSB-1 : 0]     addr,
    input   logic   [nf_pkg::DATA_W-1 : 0]      wd,
    output  logic   [nf_pkg::DATA_W-1 : 0]      rd,
    // output
    output  logic   [0 : 0]                     pwm
);

    logic   [pwm_w-1 : 0]   duty;
    logic   [pwm_w-1 : 0]   presc;
    logic   [pwm_w-1 : 0]   presc_cnt;
    logic   [pwm_w-1 : 0]   period_cnt;
    logic   [0 : 0]         tick;                       // prescaler strobe

    assign tick = (presc_cnt == presc);

    always_ff @(posedge clk) begin
        if (rst) begin
            duty       <= '0;
            presc      <= '0;
            presc_cnt  <= '0;
            period_cnt <= '0;
            pwm        <= 1'b0;
        end else begin
            if (we && addr == nf_pkg::PWM_DUTY_OFS)  duty  <= wd[pwm_w-1 : 0];
            if (we && addr == nf_pkg::PWM_PRESC_OFS) presc <= wd[pwm_w-1 : 0];
            presc_cnt <= tick ? '0 : presc_cnt + 1'b1;
            if (tick)
                period_cnt <= period_cnt + 1'b1;        // wraps at 2^pwm_w
            pwm <= (period_cnt < duty);                 // duty 0 keeps it low
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            case (addr)
                nf_pkg::PWM_DUTY_OFS  : rd <= nf_pkg::DATA_W'(duty);
                nf_pkg::PWM_PRESC_OFS : rd <= nf_pkg::DATA_W'(presc);
                default               : rd <= '0;
            endcase
        end
    end

endmodule : nf_pwm

`default_nettype wire

// ==== src/nf_periph_top.sv ====
//**************************************************
// peripheral subsystem top level
//   AXI4-Lite front end and address router
//   data RAM, GPIO and PWM slaves
//   slot 3 left unmapped
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_periph_top
#(
    parameter int gpio_w    = 8,
    parameter int pwm_w     = 8,
    parameter int ram_depth = 64
)(
    input   logic   [0 : 0]                 clk,
    input   logic   [0 : 0]                 rst,
    // AXI4-Lite slave port
    input   logic   [0 : 0]                 awvalid,
    output  logic   [0 : 0]                 awready,
    input   logic   [nf_pkg::ADDR_W-1 : 0]  awaddr,
    input   logic   [0 : 0]                 wvalid,
    output  logic   [0 : 0]                 wready,
    input   logic   [nf_pkg::DATA_W-1 : 0]  wdata,
    input   logic   [3 : 0]                 wstrb,
    output  logic   [0 : 0]                 bvalid,
    input   logic   [0 : 0]                 bready,
    output  nf_pkg::resp_t                  bresp,
    input   logic   [0 : 0]                 arvalid,
    output  logic   [0 : 0]                 arready,
    input   logic   [nf_pkg::ADDR_W-1 : 0]  araddr,
    output  logic   [0 : 0]                 rvalid,
    input   logic   [0 : 0]                 rready,
    output  logic   [nf_pkg::DATA_W-1 : 0]  rdata,
    output  nf_pkg::resp_t                  rresp,
    // pins
    input   logic   [gpio_w-1 : 0]          gpi,
    output  logic   [gpio_w-1 : 0]          gpo,
    output  logic   [gpio_w-1 : 0]          gpd,
    output  logic   [0 : 0]                 pwm
);

    logic   [nf_pkg::ADDR_W-1 : 0]                          bus_addr;
    logic   [0 : 0]                                         bus_we;
    logic   [0 : 0]                                         bus_re;
    logic   [nf_pkg::DATA_W-1 : 0]                          bus_wd;
    logic   [nf_pkg::DATA_W-1 : 0]                          bus_rd;
    logic   [0 : 0]                                         bus_err;
    logic   [nf_pkg::SEL_LSB-1 : 0]                         addr_s;
    logic   [nf_pkg::DATA_W-1 : 0]                          wd_s;
    logic   [nf_pkg::SLAVE_N-1 : 0]                         we_s;
    logic   [nf_pkg::SLAVE_N-1 : 0]                         re_s;
    logic   [nf_pkg::SLAVE_N-1 : 0][nf_pkg::DATA_W-1 : 0]   rd_s;

    assign rd_s[3] = '0;                                // empty slot

    nf_axil_slave nf_axil_slave_0 (
        .clk, .rst,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .bus_addr, .bus_we, .bus_re, .bus_wd, .bus_rd, .bus_err
    );

    nf_router nf_router_0 (
        .clk, .rst,
        .bus_addr, .bus_we, .bus_re, .bus_wd, .bus_rd, .bus_err,
        .addr_s, .wd_s, .we_s, .re_s, .rd_s
    );

    nf_ram #(.depth(ram_depth)) nf_ram_0 (
        .clk, .addr(addr_s), .wd(wd_s),
        .we(we_s[nf_pkg::SEL_RAM]), .re(re_s[nf_pkg::SEL_RAM]), .rd(rd_s[nf_pkg::SEL_RAM])
    );

    nf_gpio #(.gpio_w(gpio_w)) nf_gpio_0 (
        .clk, .rst, .addr(addr_s), .wd(wd_s),
        .we(we_s[nf_pkg::SEL_GPIO]), .re(re_s[nf_pkg::SEL_GPIO]), .rd(rd_s[nf_pkg::SEL_GPIO]),
        .gpi, .gpo, .gpd
    );

    nf_pwm #(.pwm_w(pwm_w)) nf_pwm_0 (
        .clk, .rst, .addr(addr_s), .wd(wd_s),
        .we(we_s[nf_pkg::SEL_PWM]), .re(re_s[nf_pkg::SEL_PWM]), .rd(rd_s[nf_pkg::SEL_PWM]),
        .pwm
    );

endmodule : nf_periph_top

`default_nettype wire

// ==== tb/nf_periph_properties.sv ====
//**************************************************
// AXI4-Lite handshake assertions
//   B and R responses held stable until taken
//   no double address acceptance
//   response channels idle out of reset
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_periph_properties
(
    input   logic   [0 : 0]                 clk,
    input   logic   [0 : 0]                 rst,
    input   logic   [0 : 0]                 awready,
    input   logic   [0 : 0]                 arready,
    input   logic   [0 : 0]                 bvalid,
    input   logic   [0 : 0]                 bready,
    input   nf_pkg::resp_t                  bresp,
    input   logic   [0 : 0]                 rvalid,
    input   logic   [0 : 0]                 rready,
    input   logic   [nf_pkg::DATA_W-1 : 0]  rdata,
    input   nf_pkg::resp_t                  rresp
);

    b_hold : assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))         // master not ready yet
        else $error("bvalid dropped or bresp changed before bready");

    r_hold : assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped or read payload changed before rready");

    one_addr : assert property (@(posedge clk) disable iff (rst) !(awready && arready))
        else $error("write and read address accepted in the same cycle");

    reset_idle : assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
        else $error("response valid in the cycle after reset");

endmodule : nf_periph_properties

`default_nettype wire

// ==== tb/nf_periph_tb.sv ====
//**************************************************
// directed testbench for the peripheral subsystem
//   AXI4-Lite write and read tasks with timeouts
//   compare tasks for data, responses, flags, latency
//   LFSR stimulus source
//   RAM, GPIO, PWM, unmapped slot, back-pressure
//**************************************************

`timescale 1ns/100ps
`default_nettype none

module nf_periph_tb;

    localparam int GPIO_W    = 8;
    localparam int PWM_W     = 8;
    localparam int RAM_DEPTH = 64;
    localparam int TIMEOUT   = 50;                      // cycles per handshake wait

    logic   [0 : 0]                 clk = 1'b0;
    logic   [0 : 0]                 rst;
    logic   [0 : 0]                 awvalid;
    logic   [0 : 0]                 awready;
    logic   [nf_pkg::ADDR_W-1 : 0]  awaddr;
    logic   [0 : 0]                 wvalid;
    logic   [0 : 0]                 wready;
    logic   [nf_pkg::DATA_W-1 : 0]  wdata;
    logic   [3 : 0]                 wstrb;
    logic   [0 : 0]                 bvalid;
    logic   [0 : 0]                 bready;
    nf_pkg::resp_t                  bresp;
    logic   [0 : 0]                 arvalid;
    logic   [0 : 0]                 arready;
    logic   [nf_pkg::ADDR_W-1 : 0]  araddr;
    logic   [0 : 0]                 rvalid;
    logic   [0 : 0]                 rready;
    logic   [nf_pkg::DATA_W-1 : 0]  rdata;
    nf_pkg::resp_t                  rresp;
    logic   [GPIO_W-1 : 0]          gpi;
    logic   [GPIO_W-1 : 0]          gpo;
    logic   [GPIO_W-1 : 0]          gpd;
    logic   [0 : 0]                 pwm;

    logic   [31 : 0]    lfsr     = 32'h2cf37cd1;        // stimulus state
    int                 err_cnt  = 0;
    int                 pass_cnt = 0;
    int                 fail_cnt = 0;

    nf_periph_top #(.gpio_w(GPIO_W), .pwm_w(PWM_W), .ram_depth(RAM_DEPTH)) dut_i (.*);

    bind nf_axil_slave nf_periph_properties props_i (
        .clk, .rst, .awready, .arready, .bvalid, .bready, .bresp,
        .rvalid, .rready, .rdata, .rresp
    );

    always #20 clk = ~clk;                              // 40 ns period

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31 : 0] rand_bits(input int n);
        logic   [31 : 0]    r;
        logic               fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30 : 0], fb};
            r    = {r[30 : 0], fb};
        end
        return r;
    endfunction

    // slot code in [13:12], offset below
    function automatic logic [nf_pkg::ADDR_W-1 : 0] addr_of(input logic [1 : 0] sel,
                                                            input logic [nf_pkg::SEL_LSB-1 : 0] ofs);
        return nf_pkg::ADDR_W'({sel, ofs});
    endfunction

    task automatic check_data(input logic [nf_pkg::DATA_W-1 : 0] got,
                              input logic [nf_pkg::DATA_W-1 : 0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input nf_pkg::resp_t got, input nf_pkg::resp_t exp,
                              input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input logic [0 : 0] got, input logic [0 : 0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            err_cnt++;
            $display("ERROR %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    // hold > 0 keeps bready low that long and probes with a second address
    task automatic axi_write(input logic [nf_pkg::ADDR_W-1 : 0] addr,
                             input logic [nf_pkg::DATA_W-1 : 0] data,
                             input int hold, output nf_pkg::resp_t resp);
        int n;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        bready  <= (hold == 0);
        arvalid <= (hold > 0);                          // competing read address
        araddr  <= addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("AW/W channel never accepted the write");
        end while (!(awready && wready));
        check_bit(arready, 1'b0, "arready beside a write");    // write wins
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("B channel never raised bvalid");
        end while (!bvalid);
        check_cycles(n, 1, "write handshake to bvalid");
        resp = bresp;
        if (hold > 0) begin
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                check_bit(bvalid, 1'b1, "bvalid under back-pressure");
                check_resp(bresp, resp, "held bresp");
                check_bit(arready, 1'b0, "arready while B pending");
            end
            arvalid <= 1'b0;
            bready  <= 1'b1;
            @(posedge clk);                             // B handshake here
            check_bit(bvalid, 1'b1, "bvalid at release");
        end
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [nf_pkg::ADDR_W-1 : 0] addr, input int hold,
                            output logic [nf_pkg::DATA_W-1 : 0] data,
                            output nf_pkg::resp_t resp);
        int n;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= (hold == 0);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("AR channel never accepted the read");
        end while (!arready);
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                abort_run("R channel never raised rvalid");
        end while (!rvalid);
        check_cycles(n, 2, "read handshake to rvalid");
        data = rdata;
        resp = rresp;
        if (hold > 0) begin
            arvalid <= 1'b1;
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                check_bit(rvalid, 1'b1, "rvalid under back-pressure");
                check_data(rdata, data, "held rdata");
                check_resp(rresp, resp, "held rresp");
                check_bit(arready, 1'b0, "arready while R pending");
            end
            arvalid <= 1'b0;
            rready  <= 1'b1;
            @(posedge clk);
            check_bit(rvalid, 1'b1, "rvalid at release");
        end
        rready <= 1'b0;
    endtask

    task automatic test_ram();
        logic   [nf_pkg::DATA_W-1 : 0]  exp_mem [RAM_DEPTH];   // model by word index
        logic   [nf_pkg::DATA_W-1 : 0]  data;
        nf_pkg::resp_t                  resp;
        int                             wr_words [6];
        int                             rd_words [7];
        int                             errs;
        errs     = err_cnt;
        wr_words = '{0, 1, 7, 33, 63, 69};              // 69 lands on word 5
        rd_words = '{0, 1, 7, 33, 63, 5, 97};           // 97 reads word 33
        foreach (wr_words[i]) begin
            data = rand_bits(32);
            exp_mem[wr_words[i] % RAM_DEPTH] = data;
            axi_write(addr_of(nf_pkg::SEL_RAM, nf_pkg::SEL_LSB'(wr_words[i] * 4)), data, 0, resp);
            check_resp(resp, nf_pkg::RESP_OKAY, "ram bresp");
        end
        foreach (rd_words[i]) begin
            axi_read(addr_of(nf_pkg::SEL_RAM, nf_pkg::SEL_LSB'(rd_words[i] * 4)), 0, data, resp);
            check_data(data, exp_mem[rd_words[i] % RAM_DEPTH], "ram rdata");
            check_resp(resp, nf_pkg::RESP_OKAY, "ram rresp");
        end
        end_test("ram", errs);
    endtask

    task automatic test_gpio();
        logic   [nf_pkg::DATA_W-1 : 0]  gpo_val;
        logic   [nf_pkg::DATA_W-1 : 0]  gpd_val;
        logic   [nf_pkg::DATA_W-1 : 0]  data;
        logic   [GPIO_W-1 : 0]          pin_val;
        nf_pkg::resp_t                  resp;
        int                             errs;
        errs    = err_cnt;
        gpo_val = rand_bits(32);
        gpd_val = rand_bits(32);
        axi_write(addr_of(nf_pkg::SEL_GPIO, nf_pkg::GPIO_GPO_OFS), gpo_val, 0, resp);
        check_resp(resp, nf_pkg::RESP_OKAY, "gpo bresp");
        axi_write(addr_of(nf_pkg::SEL_GPIO, nf_pkg::GPIO_GPD_OFS), gpd_val, 0, resp);
        check_resp(resp, nf_pkg::RESP_OKAY, "gpd bresp");
        check_data(nf_pkg::DATA_W'(gpo), nf_pkg::DATA_W'(gpo_val[GPIO_W-1 : 0]), "gpo pins");
        check_data(nf_pkg::DATA_W'(gpd), nf_pkg::DATA_W'(gpd_val[GPIO_W-1 : 0]), "gpd pins");
        axi_read(addr_of(nf_pkg::SEL_GPIO, nf_pkg::GPIO_GPO_OFS), 0, data, resp);
        check_data(data, nf_pkg::DATA_W'(gpo_val[GPIO_W-1 : 0]), "gpo readback");
        axi_read(addr_of(nf_pkg::SEL_GPIO, nf_pkg::GPIO_GPD_OFS), 0, data, resp);
        check_data(data, nf_pkg::DATA_W'(gpd_val[GPIO_W-1 : 0]), "gpd readback");
        pin_val = GPIO_W'(rand_bits(GPIO_W));
        @(posedge clk);
        gpi <= pin_val;
        repeat (4) @(posedge clk);                      // past the two sync flops
        axi_read(addr_of(nf_pkg::SEL_GPIO, nf_pkg::GPIO_GPI_OFS), 0, data, resp);
        check_data(data, nf_pkg::DATA_W'(pin_val), "gpi readback");
        check_resp(resp, nf_pkg::RESP_OKAY, "gpi rresp");
        end_test("gpio", errs);
    endtask

    // one full PWM period is 2^pwm_w ticks of presc+1 clocks
    task automatic pwm_case(input int presc, input int duty);
        logic   [nf_pkg::DATA_W-1 : 0]  data;
        nf_pkg::resp_t                  resp;
        int                             high;
        axi_write(addr_of(nf_pkg::SEL_PWM, nf_pkg::PWM_PRESC_OFS),
                  nf_pkg::DATA_W'(presc), 0, resp);
        check_resp(resp, nf_pkg::RESP_OKAY, "presc bresp");
        axi_write(addr_of(nf_pkg::SEL_PWM, nf_pkg::PWM_DUTY_OFS),
                  nf_pkg::DATA_W'(duty), 0, resp);
        check_resp(resp, nf_pkg::RESP_OKAY, "duty bresp");
        axi_read(addr_of(nf_pkg::SEL_PWM, nf_pkg::PWM_DUTY_OFS), 0, data, resp);
        check_data(data, nf_pkg::DATA_W'(duty), "duty readback");
        repeat (2) @(posedge clk);                      // let the output register settle
        high = 0;
        repeat ((1 << PWM_W) * (presc + 1)) begin
            @(posedge clk);
            if (pwm)
                high++;
        end
        check_data(nf_pkg::DATA_W'(high), nf_pkg::DATA_W'(duty * (presc + 1)), "pwm high cycles");
    endtask

    task automatic test_pwm();
        int errs;
        errs = err_cnt;
        pwm_case(0, 200);                               // prescale only grows, no counter wrap
        pwm_case(2, 60);
        pwm_case(3, 0);
        end_test("pwm", errs);
    endtask

    task automatic test_unmapped();
        logic   [nf_pkg::DATA_W-1 : 0]  data;
        nf_pkg::resp_t                  resp;
        int                             errs;
        errs = err_cnt;
        axi_write(addr_of(2'd3, 12'h010), rand_bits(32), 0, resp);
        check_resp(resp, nf_pkg::RESP_SLVERR, "slot 3 bresp");
        axi_read(addr_of(2'd3, 12'h010), 0, data, resp);
        check_resp(resp, nf_pkg::RESP_SLVERR, "slot 3 rresp");
        check_data(data, '0, "slot 3 rdata");
        end_test("unmapped", errs);
    endtask

    task automatic test_backpressure();
        logic   [nf_pkg::DATA_W-1 : 0]  data;
        logic   [nf_pkg::DATA_W-1 : 0]  got;
        nf_pkg::resp_t                  resp;
        int                             errs;
        errs = err_cnt;
        data = rand_bits(32);
        axi_write(addr_of(nf_pkg::SEL_RAM, 12'h040), data, 6, resp);
        check_resp(resp, nf_pkg::RESP_OKAY, "stalled bresp");
        axi_read(addr_of(nf_pkg::SEL_RAM, 12'h040), 6, got, resp);
        check_data(got, data, "stalled rdata");
        check_resp(resp, nf_pkg::RESP_OKAY, "stalled rresp");
        end_test("backpressure", errs);
    endtask

    initial begin
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        gpi     = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_ram();
        test_gpio();
        test_pwm();
        test_unmapped();
        test_backpressure();
        $display("tests: %0d ok, %0d with mismatches", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : nf_periph_tb

`default_nettype wire

// ==== nf_periph_top.f ====
src/nf_pkg.sv
src/nf_axil_slave.sv
src/nf_router.sv
src/nf_ram.sv
src/nf_gpio.sv
src/nf_pwm.sv
src/nf_periph_top.sv
tb/nf_periph_properties.sv
tb/nf_periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module nf_periph_tb -f nf_periph_top.f
status=0
./obj_dir/Vnf_periph_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Some tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation ok"
